//--- Makefile
# Verilator build and run of the pulse-wave voice testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_pulse_gen
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Test run failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/edge_shape_ram.sv
/*
 * Scales the edge coefficients by the amplitude in a pipelined multiply
 * and stores the products in a seven-entry table with a combinational
 * read port. MUL_LATENCY counts cycles from issue to a readable entry.
 */

`timescale 1ns/1ps

module edge_shape_ram #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_mul_valid,
    input  synth_pkg::coef_idx_t i_mul_idx,
    input  synth_pkg::sample_t   i_amplitude,
    input  synth_pkg::coef_idx_t i_rd_idx,
    output synth_pkg::sample_t   o_rd_level
);
    import synth_pkg::*;

    // Operand stage, then product stages; the table write is the last step
    localparam int STAGES = MUL_LATENCY - 1;

    logic [STAGES-1:0]  vld_q;
    coef_idx_t          idx_q [STAGES];
    sample_t            coef_q;
    sample_t            ampl_q;
    logic signed [35:0] prod_q [STAGES-1];
    sample_t            table_q [EDGE_TAPS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[STAGES-2:0], i_mul_valid};
        end
    end

    always_ff @(posedge clk) begin
        coef_q    <= EDGE_COEF[i_mul_idx];
        ampl_q    <= i_amplitude;
        idx_q[0]  <= i_mul_idx;
        prod_q[0] <= coef_q * ampl_q;
        for (int s = 1; s < STAGES; s++) begin
            idx_q[s] <= idx_q[s-1];
        end
        for (int s = 1; s < STAGES - 1; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
        // Drop the Q16 fraction
        if (vld_q[STAGES-1]) begin
            table_q[idx_q[STAGES-1]] <= prod_q[STAGES-2][33:16];
        end
    end

    assign o_rd_level = table_q[i_rd_idx];

    // Sequencer must only issue products for existing entries
    a_mul_idx_range : assert property (
        @(posedge clk) disable iff (reset)
        i_mul_valid |-> ##(STAGES) (idx_q[STAGES-1] < EDGE_TAPS)
    );

endmodule

//--- design/midi_note_tracker.sv
/*
 * Captures MIDI note-on and note-off messages and holds the current
 * note and amplitude. Pulses o_note_event one cycle after either command.
 */

`timescale 1ns/1ps

module midi_note_tracker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_midi_rdy,
    input  synth_pkg::midi_msg_t   i_midi,
    output synth_pkg::note_state_t o_note,
    output logic                   o_note_event
);
    import synth_pkg::*;

    logic note_on;
    logic note_off;

    assign note_on  = i_midi_rdy && (i_midi.cmd == MIDI_CMD_NOTE_ON);
    assign note_off = i_midi_rdy && (i_midi.cmd == MIDI_CMD_NOTE_OFF);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_note       <= '0;
            o_note_event <= 1'b0;
        end else begin
            o_note_event <= note_on || note_off;
            if (note_on) begin
                o_note.note      <= i_midi.data0;
                o_note.amplitude <= {2'b00, i_midi.data1, 9'h000};
            end else if (note_off) begin
                // Keep the pitch, silence the voice
                o_note.amplitude <= '0;
            end
        end
    end

endmodule

//--- design/pitch_divider.sv
/*
 * Note-to-period divider. Wraps every period+1 cycles and raises a
 * period event that stays set until the sequencer acknowledges it.
 */

`timescale 1ns/1ps

module pitch_divider (
    input  logic             clk,
    input  logic             reset,
    input  synth_pkg::note_t i_note,
    input  logic             i_period_ack,
    output logic             o_period_event
);
    import synth_pkg::*;

    logic [3:0] semitone;
    logic [3:0] octave;
    period_t    period;
    period_t    cnt;
    logic       wrap;

    // One octave up halves the period
    always_comb begin
        semitone = 4'(i_note % 7'd12);
        octave   = 4'(i_note / 7'd12);
        period   = BASE_PERIOD[semitone] >> octave;
    end

    assign wrap = (cnt >= period);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt            <= '0;
            o_period_event <= 1'b0;
        end else begin
            cnt <= wrap ? '0 : cnt + 24'd1;
            if (wrap) begin
                o_period_event <= 1'b1;
            end else if (i_period_ack) begin
                o_period_event <= 1'b0;
            end
        end
    end

    a_period_nonzero : assert property (
        @(posedge clk) disable iff (reset) period != '0
    );

endmodule

//--- design/pulse_gen_top.sv
/*
 * Top level of the pulse-wave voice. MIDI in, one signed sample per
 * accepted sample-rate trigger out.
 */

`timescale 1ns/1ps

module pulse_gen_top #(
    parameter int MUL_LATENCY = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_midi_rdy,
    input  synth_pkg::midi_msg_t i_midi,
    input  logic                 i_sample_trig,
    output logic                 o_sample_valid,
    output synth_pkg::sample_t   o_sample
);
    import synth_pkg::*;

    note_state_t note;
    logic        note_event;
    logic        period_event;
    logic        period_ack;
    logic        mul_valid;
    coef_idx_t   idx;
    sample_t     level;

    midi_note_tracker u_tracker (
        .clk          (clk),
        .reset        (reset),
        .i_midi_rdy   (i_midi_rdy),
        .i_midi       (i_midi),
        .o_note       (note),
        .o_note_event (note_event)
    );

    pitch_divider u_divider (
        .clk            (clk),
        .reset          (reset),
        .i_note         (note.note),
        .i_period_ack   (period_ack),
        .o_period_event (period_event)
    );

    // Same index drives the product write and the level read
    edge_shape_ram #(
        .MUL_LATENCY (MUL_LATENCY)
    ) u_edge_ram (
        .clk         (clk),
        .reset       (reset),
        .i_mul_valid (mul_valid),
        .i_mul_idx   (idx),
        .i_amplitude (note.amplitude),
        .i_rd_idx    (idx),
        .o_rd_level  (level)
    );

    pulse_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .i_sample_trig  (i_sample_trig),
        .i_note_event   (note_event),
        .i_period_event (period_event),
        .i_level        (level),
        .o_mul_valid    (mul_valid),
        .o_idx          (idx),
        .o_period_ack   (period_ack),
        .o_sample_valid (o_sample_valid),
        .o_sample       (o_sample)
    );

endmodule

//--- design/pulse_microcode.sv
/*
 * Waveform program ROM. Maps the program counter and the sequencer
 * status to one micro-operation word; all conditions live here.
 */

`timescale 1ns/1ps

module pulse_microcode (
    input  synth_pkg::pc_t  i_pc,
    input  logic            i_note_changed,
    input  logic            i_period_event,
    input  logic            i_idx_last,
    input  logic            i_idx_first,
    input  logic            i_idx_one,
    output synth_pkg::uop_t o_uop
);
    import synth_pkg::*;

    always_comb begin
        o_uop = '0;
        case (i_pc)
            // Restart, recompute table only on a new note
            5'd0: begin
                o_uop.mov_i_0          = 1'b1;
                o_uop.clr_note_changed = i_note_changed;
                o_uop.jp_2             = !i_note_changed;
            end
            5'd1: begin
                o_uop.repeat_taps = 1'b1;
                o_uop.mul_ai_ampl = 1'b1;
                o_uop.mov_i_0     = i_idx_last;
                o_uop.inc_i       = !i_idx_last;
            end

            // ----------------------------------------
            // Positive half
            // ----------------------------------------
            5'd2, 5'd5, 5'd8, 5'd11, 5'd14, 5'd17: begin
                o_uop.wait_trig = 1'b1;
            end
            5'd3, 5'd6, 5'd9: begin
                o_uop.out_pos = 1'b1;
            end
            5'd4, 5'd13: begin
                o_uop.inc_i   = !i_idx_last;
                o_uop.jp_up_2 = !i_idx_last;
            end
            5'd7, 5'd16: begin
                // Hold until the divider wraps
                o_uop.jp_up_2       = !i_period_event;
                o_uop.clr_div_event = i_period_event;
            end
            5'd10: begin
                o_uop.dec_i   = !i_idx_first;
                o_uop.jp_up_2 = !i_idx_first;
                o_uop.inc_i   = i_idx_first;
            end

            // ----------------------------------------
            // Negative half
            // ----------------------------------------
            5'd12, 5'd15, 5'd18: begin
                o_uop.out_neg = 1'b1;
            end
            5'd19: begin
                o_uop.dec_i   = !i_idx_one;
                o_uop.jp_up_2 = !i_idx_one;
            end

            default: begin
                o_uop.jp_0 = 1'b1;
            end
        endcase
    end

endmodule

//--- design/pulse_sequencer.sv
/*
 * Microcoded sequencer. Steps the program counter, index register and
 * repeat counter from the ROM word, keeps the note-changed flag and
 * registers the signed output sample.
 */

`timescale 1ns/1ps

module pulse_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_sample_trig,
    input  logic                 i_note_event,
    input  logic                 i_period_event,
    input  synth_pkg::sample_t   i_level,
    output logic                 o_mul_valid,
    output synth_pkg::coef_idx_t o_idx,
    output logic                 o_period_ack,
    output logic                 o_sample_valid,
    output synth_pkg::sample_t   o_sample
);
    import synth_pkg::*;

    pc_t       pc;
    uop_t      uop;
    coef_idx_t rep_cnt;
    logic      rep_busy;
    logic      note_changed;
    logic      hold;

    pulse_microcode u_microcode (
        .i_pc           (pc),
        .i_note_changed (note_changed),
        .i_period_event (i_period_event),
        .i_idx_last     (o_idx == coef_idx_t'(EDGE_TAPS - 1)),
        .i_idx_first    (o_idx == 3'd0),
        .i_idx_one      (o_idx == 3'd1),
        .o_uop          (uop)
    );

    // Repeat runs EDGE_TAPS cycles on the same pc
    assign rep_busy = uop.repeat_taps && (rep_cnt != coef_idx_t'(EDGE_TAPS - 1));
    assign hold     = (uop.wait_trig && !i_sample_trig) || rep_busy;

    assign o_mul_valid  = uop.mul_ai_ampl;
    assign o_period_ack = uop.clr_div_event;

    // ----------------------------------------
    // Program counter and index
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            o_idx   <= '0;
            rep_cnt <= '0;
        end else begin
            if (uop.jp_0) begin
                pc <= 5'd0;
            end else if (uop.jp_2) begin
                pc <= 5'd2;
            end else if (uop.jp_up_2) begin
                pc <= pc - 5'd2;
            end else if (!hold) begin
                pc <= pc + 5'd1;
            end

            if (uop.mov_i_0) begin
                o_idx <= '0;
            end else if (uop.inc_i) begin
                o_idx <= o_idx + 3'd1;
            end else if (uop.dec_i) begin
                o_idx <= o_idx - 3'd1;
            end

            rep_cnt <= rep_busy ? rep_cnt + 3'd1 : '0;
        end
    end

    // Set wins over the clear from pc 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            note_changed <= 1'b1;
        end else if (i_note_event) begin
            note_changed <= 1'b1;
        end else if (uop.clr_note_changed) begin
            note_changed <= 1'b0;
        end
    end

    // ----------------------------------------
    // Output sample
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            o_sample_valid <= 1'b0;
            o_sample       <= '0;
        end else begin
            o_sample_valid <= uop.out_pos || uop.out_neg;
            if (uop.out_pos) begin
                o_sample <= i_level;
            end else if (uop.out_neg) begin
                o_sample <= -i_level;
            end
        end
    end

    a_pc_range : assert property (
        @(posedge clk) disable iff (reset) pc <= PROG_LAST
    );

endmodule

//--- design/synth_pkg.sv
/*
 * Shared types and constants for the MIDI pulse-wave voice.
 * Imported by every design module and by the testbench.
 */

package synth_pkg;

    // ----------------------------------------
    // Basic types
    // ----------------------------------------
    typedef logic signed [17:0] sample_t;
    typedef logic [23:0]        period_t;
    typedef logic [6:0]         note_t;
    typedef logic [2:0]         coef_idx_t;
    typedef logic [4:0]         pc_t;

    localparam int  EDGE_TAPS = 7;
    localparam pc_t PROG_LAST = 5'd20;

    // ----------------------------------------
    // MIDI
    // ----------------------------------------
    localparam logic [3:0] MIDI_CMD_NOTE_OFF = 4'h8;
    localparam logic [3:0] MIDI_CMD_NOTE_ON  = 4'h9;

    typedef struct packed {
        logic [3:0] cmd;
        logic [3:0] channel;
        note_t      data0;
        logic [6:0] data1;
    } midi_msg_t;

    // Amplitude is velocity at bits 15..9
    typedef struct packed {
        note_t   note;
        sample_t amplitude;
    } note_state_t;

    // ----------------------------------------
    // Micro-operation word
    // ----------------------------------------
    typedef struct packed {
        logic mov_i_0;
        logic inc_i;
        logic dec_i;
        logic jp_0;
        logic jp_2;
        logic jp_up_2;
        logic repeat_taps;
        logic wait_trig;
        logic mul_ai_ampl;
        logic out_pos;
        logic out_neg;
        logic clr_div_event;
        logic clr_note_changed;
    } uop_t;

    // ----------------------------------------
    // Tables
    // ----------------------------------------
    // Lowest octave, notes 0 to 11, in clock cycles
    localparam period_t BASE_PERIOD [12] = '{
        24'h5d5084, 24'h5813c2, 24'h532240, 24'h4e77c5,
        24'h4a1054, 24'h45e82b, 24'h41fbbc, 24'h3e47ac,
        24'h3ac8d3, 24'h377c32, 24'h345efa, 24'h316e80
    };

    // Edge ramp, 0 up to 1.0 in Q16
    localparam sample_t EDGE_COEF [EDGE_TAPS] = '{
        18'h00000, 18'h01dd0, 18'h05442, 18'h085fa,
        18'h0b974, 18'h0ed78, 18'h10000
    };

endpackage

//--- project.f
design/synth_pkg.sv
design/midi_note_tracker.sv
design/pitch_divider.sv
design/edge_shape_ram.sv
design/pulse_microcode.sv
design/pulse_sequencer.sv
design/pulse_gen_top.sv
test/tb_pulse_gen.sv

//--- test/tb_pulse_gen.sv
/*
 * Directed testbench for the pulse-wave voice. Sends MIDI notes and
 * sample triggers and checks every output sample against a reference model.
 */

`timescale 1ns/1ps

module tb_pulse_gen;
    import synth_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int TRIG_GAP       = 8;
    localparam int TEST_NOTE      = 127;
    localparam int IDLE_SAMPLES   = 24;
    localparam int SILENT_SAMPLES = 40;
    localparam int RAND_SEED      = 95507;

    logic      clk;
    logic      reset;
    logic      i_midi_rdy;
    midi_msg_t i_midi;
    logic      i_sample_trig;
    logic      o_sample_valid;
    sample_t   o_sample;

    sample_t   samples[$];
    logic      trig_en     = 1'b0;
    int        trig_count  = 0;
    int        valid_count = 0;
    int        checks      = 0;
    int        err_count   = 0;

    pulse_gen_top #(
        .MUL_LATENCY (3)
    ) uut (
        .clk            (clk),
        .reset          (reset),
        .i_midi_rdy     (i_midi_rdy),
        .i_midi         (i_midi),
        .i_sample_trig  (i_sample_trig),
        .o_sample_valid (o_sample_valid),
        .o_sample       (o_sample)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // One trigger every TRIG_GAP cycles while enabled
    initial begin
        int phase;
        phase = 0;
        i_sample_trig = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (trig_en && phase == 0) begin
                i_sample_trig = 1'b1;
                trig_count++;
            end else begin
                i_sample_trig = 1'b0;
            end
            phase = (phase + 1) % TRIG_GAP;
        end
    end

    always @(posedge clk) begin
        if (!reset && o_sample_valid) begin
            samples.push_back(o_sample);
            valid_count++;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic period_t period_of(input note_t n);
        return BASE_PERIOD[n % 12] >> (n / 12);
    endfunction

    // Velocity sits at bits 15..9
    function automatic sample_t amp_of(input logic [6:0] vel);
        sample_t a;
        a = '0;
        a[15:9] = vel;
        return a;
    endfunction

    function automatic sample_t level_of(input int idx, input sample_t amp, input logic neg);
        longint  prod;
        sample_t lvl;
        prod = longint'(EDGE_COEF[idx]) * longint'(amp);
        lvl  = sample_t'(prod >>> 16);
        return neg ? -lvl : lvl;
    endfunction

    // Rough upper bound for one full waveform at the test note
    function automatic int voice_cycles();
        return 2 * (int'(period_of(7'(TEST_NOTE))) + 1) + 40 * TRIG_GAP;
    endfunction

    function automatic logic [6:0] pick_velocity(input logic [6:0] avoid);
        logic [6:0] v;
        v = avoid;
        while (v == avoid) begin
            v = 7'(($urandom % 127) + 1);
        end
        return v;
    endfunction

    initial begin
        int budget;
        budget = 4 * voice_cycles() + (IDLE_SAMPLES + SILENT_SAMPLES + 40) * TRIG_GAP + 64;
        budget = budget + budget / 5;
        repeat (budget) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", budget);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ----------------------------------------
    // Compare tasks and stimulus helpers
    // ----------------------------------------
    task automatic check_sample(input string what, input sample_t got, input sample_t exp);
        checks++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t: %s sample %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int lo, input int hi);
        checks++;
        if (got < lo || got > hi) begin
            err_count++;
            $display("ERR @%0t: %s count %0d, expected %0d to %0d", $time, what, got, lo, hi);
        end
    endtask

    task automatic wait_sample();
        int waited;
        waited = 0;
        while (samples.size() == 0 && waited < 4 * TRIG_GAP) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic next_sample(output sample_t s);
        wait_sample();
        if (samples.size() == 0) begin
            err_count++;
            $display("No output sample arrived within %0d cycles at %0t", 4 * TRIG_GAP, $time);
            s = '0;
        end else begin
            s = samples.pop_front();
        end
    endtask

    // Run of equal samples, the first different one stays queued
    task automatic count_run(input sample_t value, output int run);
        logic more;
        run  = 0;
        more = 1'b1;
        while (more) begin
            wait_sample();
            if (samples.size() != 0 && samples[0] === value) begin
                void'(samples.pop_front());
                run++;
            end else begin
                more = 1'b0;
            end
        end
    endtask

    task automatic check_ramp(input string what, input sample_t amp, input logic neg,
                              input int from, input int to);
        int      step;
        sample_t s;
        step = (to >= from) ? 1 : -1;
        for (int i = from; i != to + step; i += step) begin
            next_sample(s);
            check_sample(what, s, level_of(i, amp, neg));
        end
    endtask

    // Hold, fall and the whole negative half after a rise
    task automatic check_after_rise(input sample_t amp, output int pos_run, output int neg_run);
        int max_run;
        max_run = voice_cycles() / TRIG_GAP;
        count_run(level_of(6, amp, 1'b0), pos_run);
        check_count("positive hold", pos_run, 2, max_run);
        check_ramp("fall", amp, 1'b0, 5, 0);
        check_ramp("negative rise", amp, 1'b1, 1, 6);
        count_run(level_of(6, amp, 1'b1), neg_run);
        check_count("negative hold", neg_run, 2, max_run);
        check_ramp("negative fall", amp, 1'b1, 5, 1);
    endtask

    task automatic send_midi(input logic [3:0] cmd, input note_t note, input logic [6:0] vel);
        @(posedge clk);
        #1;
        i_midi_rdy     = 1'b1;
        i_midi.cmd     = cmd;
        i_midi.channel = 4'd0;
        i_midi.data0   = note;
        i_midi.data1   = vel;
        @(posedge clk);
        #1;
        i_midi_rdy = 1'b0;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_idle_silence();
        sample_t s;
        int      trig_base;
        int      valid_base;
        trig_base  = trig_count;
        valid_base = valid_count;
        trig_en    = 1'b1;
        for (int i = 0; i < IDLE_SAMPLES; i++) begin
            next_sample(s);
            check_sample("idle", s, '0);
        end
        check_count("idle pulses per trigger", valid_count - valid_base,
                    trig_count - trig_base, trig_count - trig_base);
    endtask

    task automatic test_note_on_rise(input logic [6:0] vel);
        sample_t amp;
        int      skipped;
        amp = amp_of(vel);
        send_midi(MIDI_CMD_NOTE_ON, 7'(TEST_NOTE), vel);
        // Old cycle runs out on the silent table, then level 0 of the rise
        count_run('0, skipped);
        check_count("silent samples before rise", skipped, 1, voice_cycles() / TRIG_GAP);
        check_ramp("rise", amp, 1'b0, 1, 6);
    endtask

    task automatic test_hold_and_fall(input sample_t amp);
        int pos_run;
        int neg_run;
        int per_period;
        check_after_rise(amp, pos_run, neg_run);
        // Fall, negative rise and negative hold fill one divider period
        per_period = int'(period_of(7'(TEST_NOTE))) / TRIG_GAP;
        check_count("samples per period", 12 + neg_run, per_period - 2, per_period + 2);
    endtask

    task automatic test_velocity_change(input sample_t old_amp, input logic [6:0] vel);
        sample_t new_amp;
        int      pos_run;
        int      neg_run;
        new_amp = amp_of(vel);
        check_ramp("rise before change", old_amp, 1'b0, 0, 2);
        send_midi(MIDI_CMD_NOTE_ON, 7'(TEST_NOTE), vel);
        // Table keeps the old amplitude until the next pc 0
        check_ramp("rise after change", old_amp, 1'b0, 3, 6);
        check_after_rise(old_amp, pos_run, neg_run);
        check_ramp("rise with new velocity", new_amp, 1'b0, 0, 6);
    endtask

    task automatic test_note_off_silence(input sample_t amp);
        sample_t s;
        int      pos_run;
        int      neg_run;
        send_midi(MIDI_CMD_NOTE_OFF, 7'(TEST_NOTE), 7'd0);
        check_after_rise(amp, pos_run, neg_run);
        for (int i = 0; i < SILENT_SAMPLES; i++) begin
            next_sample(s);
            check_sample("after note-off", s, '0);
        end
    endtask

    initial begin
        logic [6:0] vel1;
        logic [6:0] vel2;
        void'($urandom(RAND_SEED));
        reset      = 1'b1;
        i_midi_rdy = 1'b0;
        i_midi     = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        // Power-up recompute
        repeat (12) @(posedge clk);
        @(negedge clk);
        vel1 = pick_velocity(7'd0);
        vel2 = pick_velocity(vel1);

        test_idle_silence();
        test_note_on_rise(vel1);
        test_hold_and_fall(amp_of(vel1));
        test_velocity_change(amp_of(vel1), vel2);
        test_note_off_silence(amp_of(vel2));

        $display("Checks: %0d, errors: %0d", checks, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
